/* logic/vmem_params.svh */
`ifndef VMEM_PARAMS_SVH
`define VMEM_PARAMS_SVH

// ******************************
// widths and depths.
// ******************************
`define VMEM_ADDR_W     12
`define VMEM_WORD_W     32
`define VMEM_LANES      8
`define VMEM_ROWS       256
`define VMEM_TEXT_WORDS 512

// ******************************
// matrix inversion result words.
// ******************************
`define VMEM_MAT_L_LO   12'hA03
`define VMEM_MAT_L_HI   12'hA04
`define VMEM_MAT_U_LO   12'hA05
`define VMEM_MAT_U_HI   12'hA06

// words per factor, 8 low plus 1 high.
`define VMEM_MAT_WORDS  9

`endif

/* logic/vmem_pkg.sv */
`include "vmem_params.svh"

package vmem_pkg;

    typedef enum logic [2:0] {
        W32  = 3'd2,
        W64  = 3'd3,
        W128 = 3'd4,
        W256 = 3'd7
    } access_width_e;

    // data region view, bit 11 clear selects the banks.
    typedef struct packed {
        logic                               region;
        logic [$clog2(`VMEM_ROWS)-1:0]      row;
        logic [$clog2(`VMEM_LANES)-1:0]     lane;
    } data_addr_t;

    typedef struct packed {
        logic [`VMEM_ADDR_W-$clog2(`VMEM_TEXT_WORDS)-1:0] prefix;
        logic [$clog2(`VMEM_TEXT_WORDS)-1:0]             word;
    } text_addr_t;

    typedef union packed {
        data_addr_t data_view;
        text_addr_t text_view;
    } vmem_addr_u;

    typedef struct packed {
        logic                                 write;
        access_width_e                        width;
        vmem_addr_u                           addr;
        logic [`VMEM_LANES*`VMEM_WORD_W-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                          en;
        logic                          we;
        logic [$clog2(`VMEM_ROWS)-1:0] row;
        logic [`VMEM_WORD_W-1:0]       wdata;
    } bank_req_t;

    typedef enum logic [1:0] {
        DATA   = 2'd0,
        TEXT   = 2'd1,
        MATRIX = 2'd2,
        NONE   = 2'd3
    } region_e;

    typedef struct packed {
        logic                           valid;
        region_e                        region;
        logic [$clog2(`VMEM_LANES)-1:0] offset;
        access_width_e                  width;
        logic [1:0]                     mat_sel;
    } read_tag_t;

    typedef struct packed {
        logic [`VMEM_LANES*`VMEM_WORD_W-1:0] rdata;
        logic                                fault;
    } mem_rsp_t;

endpackage

/* logic/mem_decoder.sv */
`timescale 1ns/10ps
`include "vmem_params.svh"

module mem_decoder (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    req_valid,
    input  vmem_pkg::mem_req_t                      req,
    output vmem_pkg::bank_req_t [`VMEM_LANES-1:0]   bank_req,
    output logic                                    text_en,
    output logic                                    text_we,
    output logic [$clog2(`VMEM_TEXT_WORDS)-1:0]     text_word,
    output logic [`VMEM_WORD_W-1:0]                 text_wdata,
    output vmem_pkg::read_tag_t                     read_tag
);

    import vmem_pkg::*;

    region_e                             region;
    logic [1:0]                          mat_sel;
    logic [`VMEM_ADDR_W-1:0]             mat_offset;
    logic [`VMEM_LANES-1:0]              width_mask;
    logic [`VMEM_LANES-1:0]              lane_mask;
    logic [`VMEM_LANES*`VMEM_WORD_W-1:0] wdata_shifted;
    logic                                fault;

    // ******************************
    // region decode.
    // ******************************
    assign mat_offset = req.addr - `VMEM_MAT_L_LO;
    assign mat_sel    = mat_offset[1:0];

    always_comb begin
        if (req.addr.data_view.region == 1'b0) begin
            region = DATA;
        end else if (req.addr.text_view.prefix == 3'b100) begin
            region = TEXT;
        end else if (req.addr >= `VMEM_MAT_L_LO && req.addr <= `VMEM_MAT_U_HI) begin
            region = MATRIX;
        end else begin
            region = NONE;
        end
    end

    // matrix words are read only.
    assign fault = (region == NONE) || (region == MATRIX && req.write);

    // ******************************
    // lane mask and write alignment.
    // ******************************
    always_comb begin
        case (req.width)
            W32:     width_mask = 8'h01;
            W64:     width_mask = 8'h03;
            W128:    width_mask = 8'h0f;
            default: width_mask = 8'hff;
        endcase
    end

    // lanes past 7 fall off the top.
    assign lane_mask     = width_mask << req.addr.data_view.lane;
    assign wdata_shifted = req.wdata << {req.addr.data_view.lane, 5'b0};

    always_comb begin
        for (int i = 0; i < `VMEM_LANES; i++) begin
            bank_req[i].en    = req_valid && (region == DATA) && lane_mask[i];
            bank_req[i].we    = req.write;
            bank_req[i].row   = req.addr.data_view.row;
            bank_req[i].wdata = wdata_shifted[i*`VMEM_WORD_W +: `VMEM_WORD_W];
        end
    end

    assign text_en    = req_valid && (region == TEXT);
    assign text_we    = req.write;
    assign text_word  = req.addr.text_view.word;
    assign text_wdata = req.wdata[`VMEM_WORD_W-1:0];

    // tag for the response cycle, faulting writes return as NONE.
    always_ff @(posedge clk) begin
        if (reset) begin
            read_tag.valid <= 1'b0;
        end else begin
            read_tag.valid <= req_valid && (!req.write || fault);
        end
        read_tag.region  <= fault ? NONE : region;
        read_tag.offset  <= req.addr.data_view.lane;
        read_tag.width   <= req.width;
        read_tag.mat_sel <= mat_sel;
    end

endmodule

/* logic/data_bank.sv */
`timescale 1ns/10ps
`include "vmem_params.svh"

module data_bank (
    input  logic                    clk,
    input  vmem_pkg::bank_req_t     bank_req,
    output logic [`VMEM_WORD_W-1:0] rdata
);

    logic [`VMEM_WORD_W-1:0] mem [`VMEM_ROWS];

    // ******************************
    // single port lane array.
    // ******************************
    always_ff @(posedge clk) begin
        if (bank_req.en) begin
            if (bank_req.we) begin
                mem[bank_req.row] <= bank_req.wdata;
            end else begin
                rdata <= mem[bank_req.row];
            end
        end
    end

    // read data holds until the next read.

endmodule

/* logic/instr_mem.sv */
`timescale 1ns/10ps
`include "vmem_params.svh"

module instr_mem (
    input  logic                                clk,
    input  logic                                text_en,
    input  logic                                text_we,
    input  logic [$clog2(`VMEM_TEXT_WORDS)-1:0] text_word,
    input  logic [`VMEM_WORD_W-1:0]             text_wdata,
    output logic [`VMEM_WORD_W-1:0]             text_rdata
);

    logic [`VMEM_WORD_W-1:0] mem [`VMEM_TEXT_WORDS];

    // ******************************
    // text store, one word per cycle.
    // ******************************
    always_ff @(posedge clk) begin
        if (text_en) begin
            if (text_we) begin
                mem[text_word] <= text_wdata;
            end else begin
                text_rdata <= mem[text_word];
            end
        end
    end

endmodule

/* logic/read_return.sv */
`timescale 1ns/10ps
`include "vmem_params.svh"

module read_return (
    input  vmem_pkg::read_tag_t                           read_tag,
    input  logic [`VMEM_LANES*`VMEM_WORD_W-1:0]           row_rdata,
    input  logic [`VMEM_WORD_W-1:0]                       text_rdata,
    input  logic [`VMEM_MAT_WORDS*`VMEM_WORD_W-1:0]       mat_l,
    input  logic [`VMEM_MAT_WORDS*`VMEM_WORD_W-1:0]       mat_u,
    output logic                                          rsp_valid,
    output vmem_pkg::mem_rsp_t                            rsp
);

    import vmem_pkg::*;

    logic [`VMEM_LANES-1:0]                 lane_keep;
    logic [`VMEM_LANES*`VMEM_WORD_W-1:0]    keep_bits;
    logic [`VMEM_LANES*`VMEM_WORD_W-1:0]    row_aligned;
    logic [`VMEM_MAT_WORDS*`VMEM_WORD_W-1:0] mat_src;

    // ******************************
    // data row realignment.
    // ******************************
    always_comb begin
        case (read_tag.width)
            W32:     lane_keep = 8'h01;
            W64:     lane_keep = 8'h03;
            W128:    lane_keep = 8'h0f;
            default: lane_keep = 8'hff;
        endcase
    end

    always_comb begin
        for (int i = 0; i < `VMEM_LANES; i++) begin
            keep_bits[i*`VMEM_WORD_W +: `VMEM_WORD_W] = {`VMEM_WORD_W{lane_keep[i]}};
        end
    end

    assign row_aligned = row_rdata >> {read_tag.offset, 5'b0};

    // upper select bit picks U over L.
    assign mat_src = read_tag.mat_sel[1] ? mat_u : mat_l;

    always_comb begin
        rsp.fault = 1'b0;
        case (read_tag.region)
            DATA:    rsp.rdata = row_aligned & keep_bits;
            TEXT:    rsp.rdata = {{(`VMEM_LANES-1)*`VMEM_WORD_W{1'b0}}, text_rdata};
            MATRIX: begin
                if (read_tag.mat_sel[0]) begin
                    // high half is word 8 alone.
                    rsp.rdata = {{(`VMEM_LANES-1)*`VMEM_WORD_W{1'b0}},
                                 mat_src[`VMEM_LANES*`VMEM_WORD_W +: `VMEM_WORD_W]};
                end else begin
                    rsp.rdata = mat_src[`VMEM_LANES*`VMEM_WORD_W-1:0];
                end
            end
            default: begin
                rsp.rdata = '0;
                rsp.fault = 1'b1;
            end
        endcase
    end

    assign rsp_valid = read_tag.valid;

endmodule

/* logic/vmem_subsystem.sv */
`timescale 1ns/10ps
`include "vmem_params.svh"

module vmem_subsystem (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    req_valid,
    input  vmem_pkg::mem_req_t                      req,
    input  logic [`VMEM_MAT_WORDS*`VMEM_WORD_W-1:0] mat_l,
    input  logic [`VMEM_MAT_WORDS*`VMEM_WORD_W-1:0] mat_u,
    output logic                                    rsp_valid,
    output vmem_pkg::mem_rsp_t                      rsp
);

    import vmem_pkg::*;

    bank_req_t [`VMEM_LANES-1:0]            bank_req;
    read_tag_t                              read_tag;
    logic                                   text_en;
    logic                                   text_we;
    logic [$clog2(`VMEM_TEXT_WORDS)-1:0]    text_word;
    logic [`VMEM_WORD_W-1:0]                text_wdata;
    logic [`VMEM_WORD_W-1:0]                text_rdata;
    logic [`VMEM_LANES*`VMEM_WORD_W-1:0]    row_rdata;

    // ******************************
    // request side.
    // ******************************
    mem_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .bank_req   (bank_req),
        .text_en    (text_en),
        .text_we    (text_we),
        .text_word  (text_word),
        .text_wdata (text_wdata),
        .read_tag   (read_tag)
    );

    // one bank per lane, lane i in bits i*32 up.
    for (genvar i = 0; i < `VMEM_LANES; i++) begin : g_bank
        data_bank u_bank (
            .clk      (clk),
            .bank_req (bank_req[i]),
            .rdata    (row_rdata[i*`VMEM_WORD_W +: `VMEM_WORD_W])
        );
    end

    instr_mem u_text (
        .clk        (clk),
        .text_en    (text_en),
        .text_we    (text_we),
        .text_word  (text_word),
        .text_wdata (text_wdata),
        .text_rdata (text_rdata)
    );

    // ******************************
    // response side.
    // ******************************
    read_return u_return (
        .read_tag   (read_tag),
        .row_rdata  (row_rdata),
        .text_rdata (text_rdata),
        .mat_l      (mat_l),
        .mat_u      (mat_u),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule

/* testbench/vmem_tb.sv */
`timescale 1ns/10ps
`include "vmem_params.svh"

module vmem_tb;

    import vmem_pkg::*;

    // reset, preload, six tests and the closing idle cycles.
    localparam int TEST_CYCLES = 4 + 48 + 6 + 9 + 5 + 10 + 13 + 202 + 3;
    localparam int MAX_CYCLES  = TEST_CYCLES + 50;

    logic                                    clk = 1'b0;
    logic                                    reset;
    logic                                    req_valid;
    mem_req_t                                req;
    logic [`VMEM_MAT_WORDS*`VMEM_WORD_W-1:0] mat_l;
    logic [`VMEM_MAT_WORDS*`VMEM_WORD_W-1:0] mat_u;
    logic                                    rsp_valid;
    mem_rsp_t                                rsp;

    logic [31:0] ref_data [2048];
    logic [31:0] ref_text [512];
    logic        next_valid;
    logic        exp_valid;
    mem_rsp_t    next_rsp;
    mem_rsp_t    exp_rsp;
    int          seed   = 12;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    vmem_subsystem dut (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .mat_l     (mat_l),
        .mat_u     (mat_u),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    always #2 clk = ~clk;

    // expected response lines up with the registered tag.
    always @(posedge clk) begin
        if (reset) begin
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= next_valid;
            exp_rsp   <= next_rsp;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!reset && exp_valid) begin
            checks <= checks + 1;
        end
    end

    // ******************************
    // response checks.
    // ******************************
    valid_check: assert property (@(posedge clk) disable iff (reset) rsp_valid == exp_valid)
        else begin
            $display("FAILED %0t rsp_valid got %0b expected %0b",
                     $time, $sampled(rsp_valid), $sampled(exp_valid));
            errors++;
        end

    data_check: assert property (@(posedge clk) disable iff (reset)
                                 exp_valid |-> rsp.rdata == exp_rsp.rdata)
        else begin
            $display("FAILED %0t rsp.rdata got %h expected %h",
                     $time, $sampled(rsp.rdata), $sampled(exp_rsp.rdata));
            errors++;
        end

    fault_check: assert property (@(posedge clk) disable iff (reset)
                                  exp_valid |-> rsp.fault == exp_rsp.fault)
        else begin
            $display("FAILED %0t rsp.fault got %0b expected %0b",
                     $time, $sampled(rsp.fault), $sampled(exp_rsp.fault));
            errors++;
        end

    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ******************************
    // stimulus and reference model.
    // ******************************
    function automatic int lanes_of(input logic [2:0] wcode);
        case (wcode)
            3'd2:    return 1;
            3'd3:    return 2;
            3'd4:    return 4;
            default: return 8;
        endcase
    endfunction

    function automatic logic [31:0] fill_word(input logic [11:0] a);
        return {a, 8'h5a, ~a};
    endfunction

    task automatic rand_row(output logic [255:0] v);
        for (int k = 0; k < 8; k++) begin
            v[k*32 +: 32] = $random(seed);
        end
    endtask

    task automatic issue(input logic wr, input logic [2:0] wcode,
                         input logic [11:0] addr, input logic [255:0] wdata);
        int       lanes;
        int       lane;
        int       base;
        int       sel;
        logic     bad;
        mem_rsp_t pred;
        @(negedge clk);
        lanes = lanes_of(wcode);
        base  = {addr[10:3], 3'b000};
        sel   = addr - 12'hA03;
        pred  = '0;
        bad   = 1'b0;
        if (addr < 12'h800) begin
            for (int k = 0; k < lanes; k++) begin
                lane = addr[2:0] + k;
                if (lane < 8 && wr) begin
                    ref_data[base + lane] = wdata[k*32 +: 32];
                end else if (lane < 8) begin
                    pred.rdata[k*32 +: 32] = ref_data[base + lane];
                end
            end
        end else if (addr < 12'hA00) begin
            if (wr) begin
                ref_text[addr[8:0]] = wdata[31:0];
            end else begin
                pred.rdata[31:0] = ref_text[addr[8:0]];
            end
        end else if (addr >= 12'hA03 && addr <= 12'hA06 && !wr) begin
            case (sel)
                0:       pred.rdata = mat_l[255:0];
                1:       pred.rdata[31:0] = mat_l[287:256];
                2:       pred.rdata = mat_u[255:0];
                default: pred.rdata[31:0] = mat_u[287:256];
            endcase
        end else begin
            bad = 1'b1;
        end
        pred.fault = bad;
        req_valid  = 1'b1;
        req.write  = wr;
        req.width  = access_width_e'(wcode);
        req.addr   = addr;
        req.wdata  = wdata;
        next_valid = !wr || bad;
        next_rsp   = pred;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            req_valid  = 1'b0;
            next_valid = 1'b0;
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        $display("%s done, %0d errors", name, errors - err_start);
    endtask

    initial begin
        logic [255:0] row;
        logic [31:0]  r;
        logic [11:0]  a;
        int           err_start;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        next_valid = 1'b0;
        next_rsp   = '0;
        for (int k = 0; k < 9; k++) begin
            mat_l[k*32 +: 32] = $random(seed);
            mat_u[k*32 +: 32] = $random(seed);
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // rows 0 to 15 and text words 0 to 31 get known contents.
        for (int i = 0; i < 16; i++) begin
            for (int k = 0; k < 8; k++) begin
                row[k*32 +: 32] = fill_word({1'b0, 8'(i), 3'(k)});
            end
            issue(1'b1, 3'd7, {1'b0, 8'(i), 3'd0}, row);
        end
        for (int i = 0; i < 32; i++) begin
            issue(1'b1, 3'd2, {3'b100, 9'(i)}, {224'b0, fill_word({3'b100, 9'(i)})});
        end

        err_start = errors;
        rand_row(row);
        issue(1'b1, 3'd7, 12'h028, row);
        issue(1'b0, 3'd7, 12'h028, '0);
        issue(1'b0, 3'd7, 12'h028, '0);
        issue(1'b0, 3'd0, 12'h010, '0);
        idle(2);
        end_test("full row write and read", err_start);

        err_start = errors;
        rand_row(row);
        issue(1'b1, 3'd4, 12'h036, row);
        issue(1'b0, 3'd7, 12'h030, '0);
        issue(1'b0, 3'd3, 12'h035, '0);
        issue(1'b0, 3'd4, 12'h036, '0);
        issue(1'b0, 3'd2, 12'h037, '0);
        issue(1'b1, 3'd3, 12'h03b, row);
        issue(1'b0, 3'd7, 12'h038, '0);
        idle(2);
        end_test("narrow write and read", err_start);

        err_start = errors;
        rand_row(row);
        issue(1'b1, 3'd7, 12'h80b, row);
        issue(1'b0, 3'd7, 12'h80b, '0);
        issue(1'b0, 3'd7, 12'h008, '0);
        idle(2);
        end_test("text write and read", err_start);

        err_start = errors;
        for (int i = 0; i < 4; i++) begin
            issue(1'b0, 3'd7, 12'hA03 + 12'(i), '0);
            issue(1'b0, 3'd2, 12'hA03 + 12'(i), '0);
        end
        idle(2);
        end_test("matrix reads", err_start);

        err_start = errors;
        rand_row(row);
        issue(1'b1, 3'd7, 12'h200, row);
        issue(1'b1, 3'd7, 12'h210, row);
        rand_row(row);
        issue(1'b0, 3'd7, 12'hA00, '0);
        issue(1'b0, 3'd2, 12'hFFF, '0);
        issue(1'b1, 3'd7, 12'hA04, row);
        issue(1'b1, 3'd2, 12'hA10, row);
        issue(1'b0, 3'd7, 12'hA04, '0);
        // rows 64 and 66, text words 4 and 16 alias the faulting writes.
        issue(1'b0, 3'd7, 12'h200, '0);
        issue(1'b0, 3'd7, 12'h210, '0);
        issue(1'b0, 3'd7, 12'h804, '0);
        issue(1'b0, 3'd7, 12'h810, '0);
        idle(2);
        end_test("faults", err_start);

        err_start = errors;
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0, 2'd1: a = {1'b0, 4'b0, r[9:6], r[12:10]};
                2'd2:       a = {3'b100, 4'b0, r[17:13]};
                default: begin
                    case (r[21:20])
                        2'd0, 2'd1: a = 12'hA03 + 12'(r[19:18]);
                        2'd2:       a = 12'hA07 + 12'(r[27:22]);
                        default:    a = {2'b11, r[31:22]};
                    endcase
                end
            endcase
            rand_row(row);
            issue(r[2], r[5:3], a, row);
        end
        idle(2);
        end_test("random requests", err_start);

        idle(3);
        $display("tests 6, responses checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+logic
logic/vmem_pkg.sv
logic/mem_decoder.sv
logic/data_bank.sv
logic/instr_mem.sv
logic/read_return.sv
logic/vmem_subsystem.sv
testbench/vmem_tb.sv
